// File: Makefile
TOP = tb_exec_unit

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "Simulation completed successfully" > /dev/null

clean:
	rm -rf obj_dir

// File: design/apb_uop_port.sv
// APB slave: address decode, command latch, lat/wb sequencer, status and dump reads
module apb_uop_port
    import cpu_pkg::*;
    import uop_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output step_t       regs_ctl,
    output logic        exf,
    output reg_code_t   dump_addr,
    input  logic [7:0]  dump_byte,
    input  flags_t      flags,
    input  flags_t      flags_alt,
    input  logic [1:0]  rfp
);

    typedef enum logic [1:0] {
        S_IDLE = 2'd0,
        S_LAT  = 2'd1,
        S_WB   = 2'd2
    } seq_t;

    seq_t state;
    uop_t cmd;
    logic access;
    logic is_cmd;
    logic is_exf;
    logic is_stat;
    logic is_dump;
    logic addr_ok;
    logic take_cmd;

    assign access  = psel && penable && pready;  // completing transfer
    assign is_cmd  = (paddr == CMD_ADDR);
    assign is_exf  = (paddr == EXF_ADDR);
    assign is_stat = (paddr == STAT_ADDR);
    assign is_dump = (paddr[11:8] == DUMP_BASE[11:8]);
    assign addr_ok = pwrite ? (is_cmd || is_exf) : (is_cmd || is_exf || is_stat || is_dump);

    assign pslverr   = access && !addr_ok;
    assign take_cmd  = access && pwrite && is_cmd;
    assign exf       = access && pwrite && is_exf;
    assign dump_addr = paddr[7:0];

    always_comb begin
        regs_ctl.uop = cmd;
        regs_ctl.lat = (state == S_LAT);
        regs_ctl.wb  = (state == S_WB);
    end

    always_comb begin
        prdata = 32'd0;
        if (is_stat)
            prdata = {14'd0, rfp, 2'd0, flags_alt, 2'd0, flags};
        else if (is_dump)
            prdata = {24'd0, dump_byte};
        else if (is_cmd)
            prdata = cmd;  // last command word
    end

    always_ff @(posedge clk) begin
        if (take_cmd)
            cmd <= uop_t'(pwdata);
    end

    // pready drops for the lat and wb cycles
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= S_IDLE;
            pready <= 1'b1;
        end else begin
            case (state)
                S_IDLE: begin
                    if (take_cmd) begin
                        state  <= S_LAT;
                        pready <= 1'b0;
                    end
                end
                S_LAT: state <= S_WB;
                S_WB: begin
                    state  <= S_IDLE;
                    pready <= 1'b1;  // results visible from here
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    a_ready_idle: assert property (@(posedge clk) disable iff (rst)
        pready |-> (state == S_IDLE));

endmodule

// File: design/core_alu.sv
// combinational sized ALU with candidate flags
module core_alu
    import cpu_pkg::*;
    import uop_pkg::*;
(
    input  logic [31:0] op0,
    input  logic [31:0] op1,
    input  logic [7:0]  imm,
    input  alu_op_t     op,
    input  size_t       size,
    output logic [31:0] rslt,
    output alu_flags_t  alu_fl
);

    logic [31:0] mask;
    logic [31:0] a;
    logic [31:0] b;
    logic [32:0] wide;   // one extra bit for the long carry
    logic        msb_a;
    logic        msb_b;
    logic        msb_r;
    logic        cout;
    logic        arith;

    always_comb begin
        case (size)
            BYTE:    mask = 32'h0000_00ff;
            WORD:    mask = 32'h0000_ffff;
            default: mask = 32'hffff_ffff;
        endcase
        a = op0 & mask;
        b = op1 & mask;
        case (op)
            OP_LD:   wide = {1'b0, b};
            OP_ADD:  wide = {1'b0, a} + {1'b0, b};
            OP_SUB:  wide = {1'b0, a} - {1'b0, b};  // borrow fills the upper bits
            OP_AND:  wide = {1'b0, a & b};
            OP_OR:   wide = {1'b0, a | b};
            OP_XOR:  wide = {1'b0, a ^ b};
            default: wide = {25'd0, imm};           // LDI and BANK
        endcase
        rslt = wide[31:0] & mask;
        case (size)
            BYTE:    {msb_a, msb_b, msb_r, cout} = {a[7], b[7], rslt[7], wide[8]};
            WORD:    {msb_a, msb_b, msb_r, cout} = {a[15], b[15], rslt[15], wide[16]};
            default: {msb_a, msb_b, msb_r, cout} = {a[31], b[31], rslt[31], wide[32]};
        endcase
        arith = (op == OP_ADD) || (op == OP_SUB);

        alu_fl.s = msb_r;
        alu_fl.z = (rslt == 32'd0);
        alu_fl.h = arith & (a[4] ^ b[4] ^ wide[4]);  // carry/borrow out of bit 3
        if (op == OP_ADD)
            alu_fl.v = (msb_a == msb_b) && (msb_r != msb_a);
        else if (op == OP_SUB)
            alu_fl.v = (msb_a != msb_b) && (msb_r != msb_a);
        else
            alu_fl.v = ~^rslt[7:0];                  // parity for the rest
        alu_fl.n = (op == OP_SUB);
        alu_fl.c = arith & cout;
    end

endmodule

// File: design/core_regs.sv
// banked register file with operand latches, main and alternate flags, bank pointer and dump port
module core_regs
    import cpu_pkg::*;
    import uop_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  step_t       regs_ctl,
    input  logic        exf,
    input  logic [31:0] rslt,
    input  flags_t      alu_fl,
    output logic [31:0] op0,
    output logic [31:0] op1,
    output flags_t      flags,
    output flags_t      flags_alt,
    output logic [1:0]  rfp,
    input  reg_code_t   dump_addr,
    output logic [7:0]  dump_byte
);

    logic [31:0] accs [NUM_ACCS];
    logic [31:0] ptrs [NUM_PTRS];
    uop_t        uop;
    reg_code_t   dst_abs;
    reg_code_t   src_abs;
    logic [31:0] dst_word;
    logic [31:0] src_word;
    logic [31:0] wr_word;
    logic [31:0] dump_word;
    flags_t      fl_next;

    // current-bank codes take the bank from rfp
    function automatic reg_code_t resolve(input reg_code_t code, input logic [1:0] bank);
        reg_code_t r;
        r = code;
        if (!code[CODE_PTR_BIT] && code[CODE_CUR_BIT])
            r[5:4] = bank;
        r[CODE_CUR_BIT] = 1'b0;
        return r;
    endfunction

    // pick the addressed part of a register and zero extend it
    function automatic logic [31:0] sized_rd(input logic [31:0] word, input size_t size,
                                             input logic [1:0] lane);
        logic [31:0] w;
        w = 32'd0;
        case (size)
            BYTE:    w[7:0]  = word[{lane, 3'b000} +: 8];
            WORD:    w[15:0] = word[{lane[1], 4'b0000} +: 16];
            default: w       = word;
        endcase
        return w;
    endfunction

    assign uop      = regs_ctl.uop;
    assign dst_abs  = resolve(uop.dst, rfp);
    assign src_abs  = resolve(uop.src, rfp);
    assign dst_word = dst_abs[CODE_PTR_BIT] ? ptrs[dst_abs[3:2]] : accs[dst_abs[5:2]];
    assign src_word = src_abs[CODE_PTR_BIT] ? ptrs[src_abs[3:2]] : accs[src_abs[5:2]];

    // bit 6 plays no part in the dump window
    assign dump_word = dump_addr[CODE_PTR_BIT] ? ptrs[dump_addr[3:2]] : accs[dump_addr[5:2]];
    assign dump_byte = dump_word[{dump_addr[1:0], 3'b000} +: 8];

    // merge the sized result into the untouched lanes
    always_comb begin
        wr_word = dst_word;
        case (uop.size)
            BYTE:    wr_word[{dst_abs[1:0], 3'b000} +: 8] = rslt[7:0];
            WORD:    wr_word[{dst_abs[1], 4'b0000} +: 16] = rslt[15:0];
            default: wr_word = rslt;
        endcase
    end

    always_comb begin
        fl_next = flags;
        case (uop.rule)
            CC_ARITH: fl_next = alu_fl;
            CC_LOGIC: begin
                fl_next.s = alu_fl.s;
                fl_next.z = alu_fl.z;
                fl_next.h = 1'b1;
                fl_next.v = ~^rslt[7:0];  // even parity of low byte
                fl_next.n = 1'b0;
                fl_next.c = 1'b0;
            end
            CC_CARRY: fl_next.c = alu_fl.c;
            default: ;
        endcase
    end

    // operand latches follow the lat step
    always_ff @(posedge clk) begin
        if (regs_ctl.lat) begin
            op0 <= sized_rd(dst_word, uop.size, dst_abs[1:0]);
            op1 <= sized_rd(src_word, uop.size, src_abs[1:0]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_ACCS; i++)
                accs[i] <= 32'd0;
            for (int i = 0; i < NUM_PTRS; i++)
                ptrs[i] <= 32'd0;
            rfp <= 2'd0;
        end else if (regs_ctl.wb) begin
            if (uop.op == OP_BANK)
                rfp <= uop.imm[1:0];  // BANK writes no register
            else if (dst_abs[CODE_PTR_BIT])
                ptrs[dst_abs[3:2]] <= wr_word;
            else
                accs[dst_abs[5:2]] <= wr_word;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags     <= '0;
            flags_alt <= '0;
        end else if (exf) begin
            flags     <= flags_alt;  // EX F,F'
            flags_alt <= flags;
        end else if (regs_ctl.wb) begin
            flags <= fl_next;
        end
    end

    // the port never overlaps the two steps
    a_step_excl: assert property (@(posedge clk) disable iff (rst)
        !(regs_ctl.lat && regs_ctl.wb));

    // word write-back lands on lane 0 or 2 only
    a_word_lane: assert property (@(posedge clk) disable iff (rst)
        (regs_ctl.wb && uop.size == WORD && uop.op != OP_BANK) |-> !uop.dst[0]);

endmodule

// File: design/cpu_pkg.sv
// architecture types: register codes, access sizes, flag set, register counts
package cpu_pkg;

    // register byte address
    // [7] pointer select, [6] current bank, [5:4] bank, [3:2] register, [1:0] lane
    typedef logic [7:0] reg_code_t;

    localparam int CODE_PTR_BIT = 7;
    localparam int CODE_CUR_BIT = 6;

    typedef enum logic [1:0] {
        BYTE = 2'd0,
        WORD = 2'd1,
        LONG = 2'd2
    } size_t;

    typedef struct packed {
        logic s;  // sign
        logic z;  // zero
        logic h;  // half carry
        logic v;  // overflow or parity
        logic n;  // last op was a subtraction
        logic c;  // carry
    } flags_t;

    // flags as proposed by the ALU, before the rule picks them
    typedef flags_t alu_flags_t;

    localparam int NUM_ACCS = 16;  // four banks of XWA/XBC/XDE/XHL
    localparam int NUM_PTRS = 4;   // XIX, XIY, XIZ, XSP

    localparam logic [1:0] XSP_IDX = 2'd3;

endpackage

// File: design/exec_unit.sv
// top level: APB command port, banked register file and ALU
module exec_unit
    import cpu_pkg::*;
    import uop_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    step_t       regs_ctl;
    logic        exf;
    reg_code_t   dump_addr;
    logic [7:0]  dump_byte;
    flags_t      flags;
    flags_t      flags_alt;
    logic [1:0]  rfp;
    logic [31:0] op0;
    logic [31:0] op1;
    logic [31:0] rslt;
    alu_flags_t  alu_fl;

    apb_uop_port u_port (
        .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .regs_ctl(regs_ctl), .exf(exf), .dump_addr(dump_addr),
        .dump_byte(dump_byte), .flags(flags), .flags_alt(flags_alt), .rfp(rfp)
    );

    core_regs u_regs (
        .clk(clk), .rst(rst), .regs_ctl(regs_ctl), .exf(exf), .rslt(rslt),
        .alu_fl(alu_fl), .op0(op0), .op1(op1), .flags(flags), .flags_alt(flags_alt),
        .rfp(rfp), .dump_addr(dump_addr), .dump_byte(dump_byte)
    );

    core_alu u_alu (
        .op0(op0), .op1(op1), .imm(regs_ctl.uop.imm), .op(regs_ctl.uop.op),
        .size(regs_ctl.uop.size), .rslt(rslt), .alu_fl(alu_fl)
    );

endmodule

// File: design/uop_pkg.sv
// micro-op encodings: ALU operations, flag rules, command and step structs, APB map
package uop_pkg;

    import cpu_pkg::*;

    typedef enum logic [2:0] {
        OP_LD   = 3'd0,  // copy source
        OP_LDI  = 3'd1,  // load immediate
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_AND  = 3'd4,
        OP_OR   = 3'd5,
        OP_XOR  = 3'd6,
        OP_BANK = 3'd7   // select register bank from imm
    } alu_op_t;

    typedef enum logic [1:0] {
        CC_KEEP  = 2'd0,  // flags untouched
        CC_ARITH = 2'd1,  // all six from the ALU
        CC_LOGIC = 2'd2,  // s/z from result, h=1, v=parity, n=c=0
        CC_CARRY = 2'd3   // only c
    } cc_rule_t;

    // one command word as written by the host
    typedef struct packed {
        reg_code_t  dst;    // [31:24]
        reg_code_t  src;    // [23:16]
        alu_op_t    op;     // [15:13]
        size_t      size;   // [12:11]
        cc_rule_t   rule;   // [10:9]
        logic       spare;  // [8]
        logic [7:0] imm;    // [7:0]
    } uop_t;

    // sequencer step towards the register file
    typedef struct packed {
        uop_t uop;
        logic lat;  // latch operands
        logic wb;   // write back result and flags
    } step_t;

    localparam logic [11:0] CMD_ADDR  = 12'h000;
    localparam logic [11:0] EXF_ADDR  = 12'h004;
    localparam logic [11:0] STAT_ADDR = 12'h008;
    localparam logic [11:0] DUMP_BASE = 12'h100;  // 256 byte window

endpackage

// File: files.f
design/cpu_pkg.sv
design/uop_pkg.sv
design/core_alu.sv
design/core_regs.sv
design/apb_uop_port.sv
design/exec_unit.sv
tests/tb_exec_unit.sv

// File: tests/tb_exec_unit.sv
// testbench for exec_unit: clock, reset, APB master, LFSR stimulus, reference model, watchdog
module tb_exec_unit
    import cpu_pkg::*;
    import uop_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // 400 commands at about 24 cycles each plus four full dumps
    localparam int WATCHDOG_CYCLES = 400 * 24 + 4 * 256 * 4 + 1000;

    logic        clk = 1'b0;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [31:0] lfsr = 32'hc83e;
    int          errors = 0;
    int          checks = 0;
    int          waits;  // pready low cycles in the last transfer
    logic [31:0] m_acc [NUM_ACCS];  // model state
    logic [31:0] m_ptr [NUM_PTRS];
    flags_t      m_fl;
    flags_t      m_fl_alt;
    logic [1:0]  m_bank;

    always #4 clk = ~clk;

    exec_unit i_exec_unit (
        .clk(clk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    function automatic uop_t make_uop(input reg_code_t dst, input reg_code_t src,
                                      input alu_op_t op, input logic [1:0] sz,
                                      input logic [1:0] rule, input logic [7:0] imm);
        uop_t u;
        u.dst   = dst;
        u.src   = src;
        u.op    = op;
        u.size  = (sz == 2'd3) ? LONG : size_t'(sz);
        u.rule  = cc_rule_t'(rule);
        u.spare = 1'b0;
        u.imm   = imm;
        if (u.size == WORD)
            u.dst[0] = 1'b0;  // words start on lane 0 or 2
        return u;
    endfunction

    function automatic reg_code_t abs_code(input reg_code_t code);
        reg_code_t r;
        r = code;
        if (!code[7] && code[6])
            r[5:4] = m_bank;
        r[6] = 1'b0;
        return r;
    endfunction

    function automatic logic [31:0] model_word(input reg_code_t code);
        return code[7] ? m_ptr[code[3:2]] : m_acc[code[5:2]];
    endfunction

    function automatic logic [31:0] model_operand(input reg_code_t code, input size_t sz);
        logic [31:0] w;
        w = model_word(code);
        case (sz)
            BYTE:    return (w >> (8 * code[1:0])) & 32'hff;
            WORD:    return (w >> (16 * code[1])) & 32'hffff;
            default: return w;
        endcase
    endfunction

    task automatic model_exec(input uop_t u);
        reg_code_t   d;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [31:0] lm;
        logic [31:0] w;
        logic [63:0] mask;
        flags_t      f;
        int          n;
        int          sh;
        d = abs_code(u.dst);
        a = model_operand(d, u.size);
        b = model_operand(abs_code(u.src), u.size);
        n = (u.size == BYTE) ? 8 : ((u.size == WORD) ? 16 : 32);
        mask = (64'd1 << n) - 64'd1;
        case (u.op)
            OP_LD:   r = b;
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            default: r = {24'd0, u.imm};  // LDI, BANK
        endcase
        r = r & mask[31:0];
        f = '0;
        f.s = r[n - 1];
        f.z = (r == 32'd0);
        f.n = (u.op == OP_SUB);
        f.v = ($countones(r[7:0]) % 2) == 0;
        if (u.op == OP_ADD) begin
            f.h = ({1'b0, a[3:0]} + {1'b0, b[3:0]}) > 5'd15;
            f.v = (a[n - 1] == b[n - 1]) && (r[n - 1] != a[n - 1]);
            f.c = (64'(a) + 64'(b)) > mask;
        end else if (u.op == OP_SUB) begin
            f.h = a[3:0] < b[3:0];
            f.v = (a[n - 1] != b[n - 1]) && (r[n - 1] != a[n - 1]);
            f.c = a < b;  // borrow
        end
        case (u.rule)
            CC_ARITH: m_fl = f;
            CC_LOGIC: m_fl = '{s: f.s, z: f.z, h: 1'b1, v: ($countones(r[7:0]) % 2) == 0,
                               n: 1'b0, c: 1'b0};
            CC_CARRY: m_fl.c = f.c;
            default: ;
        endcase
        if (u.op == OP_BANK) begin
            m_bank = u.imm[1:0];
        end else begin
            sh = (u.size == BYTE) ? 8 * d[1:0] : ((u.size == WORD) ? 16 * d[1] : 0);
            lm = mask[31:0] << sh;
            w = (model_word(d) & ~lm) | ((r << sh) & lm);
            if (d[7])
                m_ptr[d[3:2]] = w;
            else
                m_acc[d[5:2]] = w;
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            input bit chain, output logic [31:0] rdata, output logic err);
        if (!chain)
            @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        waits = 0;
        @(negedge clk);
        while (!pready) begin
            waits++;
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);  // transfer completes here
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic bus_op(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                          input logic exp_err, output logic [31:0] rdata);
        logic err;
        apb_xfer(wr, addr, wdata, 1'b0, rdata, err);
        expect_eq($sformatf("pslverr@%h", addr), {31'd0, err}, {31'd0, exp_err});
    endtask

    task automatic send_cmd(input uop_t u, input bit chain);
        logic [31:0] rd;
        logic        err;
        apb_xfer(1'b1, CMD_ADDR, u, chain, rd, err);
        expect_eq("pslverr@cmd", {31'd0, err}, 32'd0);
        model_exec(u);
    endtask

    task automatic swap_flags();
        logic [31:0] rd;
        flags_t      t;
        bus_op(1'b1, EXF_ADDR, 32'd0, 1'b0, rd);
        t = m_fl;
        m_fl = m_fl_alt;
        m_fl_alt = t;
    endtask

    task automatic check_status();
        logic [31:0] rd;
        bus_op(1'b0, STAT_ADDR, 32'd0, 1'b0, rd);
        expect_eq("status", rd, {14'd0, m_bank, 2'd0, m_fl_alt, 2'd0, m_fl});
    endtask

    task automatic check_byte(input logic [7:0] a);
        logic [31:0] rd;
        logic [31:0] w;
        bus_op(1'b0, DUMP_BASE + {4'd0, a}, 32'd0, 1'b0, rd);
        w = model_word(a) >> (8 * a[1:0]);
        expect_eq($sformatf("dump[%h]", a), rd, {24'd0, w[7:0]});
    endtask

    task automatic check_reg(input reg_code_t code);
        for (int i = 0; i < 4; i++)
            check_byte({code[7:2], i[1:0]});
    endtask

    task automatic check_dump();
        for (int i = 0; i < 256; i++)
            check_byte(i[7:0]);
    endtask

    initial begin
        alu_op_t     ops [6];
        logic [31:0] rw;
        logic [31:0] rd;
        uop_t        u;
        reg_code_t   code;
        ops = '{OP_LD, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = 12'd0;
        pwdata = 32'd0;
        m_acc = '{default: 32'd0};
        m_ptr = '{default: 32'd0};
        m_fl = '0;
        m_fl_alt = '0;
        m_bank = 2'd0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        check_status();
        check_dump();

        repeat (60) begin  // sized immediate loads
            rw = rand_bits(20);
            send_cmd(make_uop(rw[19:12], 8'd0, OP_LDI, rw[11:10], rw[9:8], rw[7:0]), 1'b0);
        end
        check_status();
        check_dump();

        repeat (250) begin
            rw = rand_bits(23);
            u = make_uop(rw[22:15], rw[14:7], ops[rw[6:4] % 3'd6], rw[3:2], rw[1:0], 8'd0);
            send_cmd(u, 1'b0);
            check_status();
            check_reg(abs_code(u.dst));
        end

        for (int b = 0; b < 4; b++) begin
            send_cmd(make_uop(8'h00, 8'h00, OP_BANK, 2'd2, 2'd0, 8'(b)), 1'b0);
            rw = rand_bits(12);
            code = {4'b0100, rw[11:10], 2'b00};  // current bank accumulator
            send_cmd(make_uop(code, 8'h00, OP_LDI, 2'd2, 2'd0, rw[7:0]), 1'b0);
            send_cmd(make_uop(code, {4'b0100, rw[9:8], 2'b00}, OP_ADD, 2'd2, 2'd1, 8'd0), 1'b0);
            check_status();
            check_reg({2'b00, 2'(b), rw[11:10], 2'b00});
        end
        check_dump();

        send_cmd(make_uop(8'h00, 8'h04, OP_SUB, 2'd0, 2'd1, 8'd0), 1'b0);
        check_status();
        swap_flags();
        check_status();
        swap_flags();
        check_status();

        bus_op(1'b0, 12'h010, 32'd0, 1'b1, rd);
        bus_op(1'b0, 12'h0fc, 32'd0, 1'b1, rd);
        bus_op(1'b1, STAT_ADDR, 32'hffff_ffff, 1'b1, rd);
        bus_op(1'b1, DUMP_BASE + 12'h25, 32'h5a, 1'b1, rd);
        check_status();
        check_dump();

        rw = rand_bits(8);
        send_cmd(make_uop(8'h84, 8'h00, OP_LDI, 2'd2, 2'd0, rw[7:0]), 1'b0);
        send_cmd(make_uop(8'h8c, 8'h84, OP_ADD, 2'd2, 2'd1, 8'd0), 1'b1);
        checks++;
        if (waits == 0) begin
            errors++;
            $display("second command was accepted while the first one was still in flight");
        end
        check_reg(8'h84);
        check_reg(8'h8c);
        check_status();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the DUT stopped responding", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

endmodule
